// ==== hdl/bp_pkg.sv ====
// shared widths and branch-kind codes; pc values are 30-bit word addresses
package bp_pkg;

    // word address width
    localparam int PC_W = 30;

    // branch-kind code width
    localparam int KIND_W = 3;

    // branch kinds as resolved by execute
    localparam logic [KIND_W-1:0] KIND_NOT = 3'd0;

    // conditional direct branch, the only kind the direction table trains on
    localparam logic [KIND_W-1:0] KIND_DIRECT = 3'd1;

    localparam logic [KIND_W-1:0] KIND_CALL = 3'd2;

    localparam logic [KIND_W-1:0] KIND_RET = 3'd3;

    localparam logic [KIND_W-1:0] KIND_INDIRECT = 3'd4;

    localparam logic [KIND_W-1:0] KIND_OTHER = 3'd5;

    // weakly not taken
    localparam logic [1:0] CTR_RESET = 2'b01;

endpackage

// ==== hdl/bp_upd_if.sv ====
// at most one merged training update per cycle; there is no ready because the tables always accept
`timescale 1ns/100ps

interface bp_upd_if;
    import bp_pkg::*;

    logic              valid;
    logic [PC_W-1:0]   pc;
    logic              taken;
    logic [KIND_W-1:0] kind;
    logic [PC_W-1:0]   npc;

    // buffer side
    modport src (output valid, pc, taken, kind, npc);

    // table side
    modport dst (input valid, pc, taken, kind, npc);

endinterface

// ==== hdl/ex_buffer.sv ====
// DEPTH must be a power of two >= 4; upstream must never push into a full queue
`timescale 1ns/100ps

module ex_buffer #(
    parameter int DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      stall,
    input  logic                      ex0_valid,
    input  logic [bp_pkg::PC_W-1:0]   ex0_pc,
    input  logic                      ex0_taken,
    input  logic [bp_pkg::KIND_W-1:0] ex0_kind,
    input  logic [bp_pkg::PC_W-1:0]   ex0_npc,
    input  logic                      ex1_valid,
    input  logic [bp_pkg::PC_W-1:0]   ex1_pc,
    input  logic                      ex1_taken,
    input  logic [bp_pkg::KIND_W-1:0] ex1_kind,
    input  logic [bp_pkg::PC_W-1:0]   ex1_npc,
    bp_upd_if.src                     upd
);
    import bp_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [PC_W-1:0]   q_pc    [DEPTH];
    logic              q_taken [DEPTH];
    logic [KIND_W-1:0] q_kind  [DEPTH];
    logic [PC_W-1:0]   q_npc   [DEPTH];

    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  head_nxt;
    logic [PTR_W-1:0]  tail;
    logic [PTR_W-1:0]  wr1_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  n_push;
    logic [CNT_W-1:0]  n_pop;
    logic              push0;
    logic              push1;
    logic [PC_W-1:0]   m_pc;
    logic              m_taken;
    logic [KIND_W-1:0] m_kind;
    logic [PC_W-1:0]   m_npc;

    // highest-priority kind of the pair
    function automatic logic [KIND_W-1:0] kind_prio(input logic [KIND_W-1:0] a,
                                                     input logic [KIND_W-1:0] b);
        if (a == KIND_DIRECT || b == KIND_DIRECT)
            return KIND_DIRECT;
        if (a == KIND_CALL || b == KIND_CALL)
            return KIND_CALL;
        if (a == KIND_RET || b == KIND_RET)
            return KIND_RET;
        if (a == KIND_INDIRECT || b == KIND_INDIRECT)
            return KIND_INDIRECT;
        if (a == KIND_OTHER || b == KIND_OTHER)
            return KIND_OTHER;
        return KIND_NOT;
    endfunction

    // ex0 always goes in ahead of ex1
    assign push0    = !stall && ex0_valid;
    assign push1    = !stall && ex1_valid;
    assign n_push   = CNT_W'(push0) + CNT_W'(push1);
    assign wr1_ptr  = push0 ? tail + PTR_W'(1) : tail;
    assign head_nxt = head + PTR_W'(1);

    // pc bit0 set at the head means a packet of one
    always_comb begin
        n_pop = '0;
        if (count != '0 && q_pc[head][0])
            n_pop = CNT_W'(1);
        else if (count >= CNT_W'(2) && !q_pc[head][0])
            n_pop = CNT_W'(2);
    end

    always_comb begin
        m_pc = q_pc[head];
        if (q_pc[head][0]) begin
            m_taken = q_taken[head];
            m_kind  = q_kind[head];
            m_npc   = q_npc[head];
        end else begin
            m_taken = q_taken[head] | q_taken[head_nxt];
            m_kind  = kind_prio(q_kind[head], q_kind[head_nxt]);
            m_npc   = q_taken[head] ? q_npc[head] : q_npc[head_nxt];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            upd.valid <= 1'b0;
        end else begin
            head      <= head + PTR_W'(n_pop);
            tail      <= tail + PTR_W'(n_push);
            count     <= count + n_push - n_pop;
            upd.valid <= (n_pop != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push0) begin
            q_pc[tail]    <= ex0_pc;
            q_taken[tail] <= ex0_taken;
            q_kind[tail]  <= ex0_kind;
            q_npc[tail]   <= ex0_npc;
        end
        if (push1) begin
            q_pc[wr1_ptr]    <= ex1_pc;
            q_taken[wr1_ptr] <= ex1_taken;
            q_kind[wr1_ptr]  <= ex1_kind;
            q_npc[wr1_ptr]   <= ex1_npc;
        end
        if (n_pop != '0) begin
            upd.pc    <= m_pc;
            upd.taken <= m_taken;
            upd.kind  <= m_kind;
            upd.npc   <= m_npc;
        end
    end

    // slots freed by this cycle's pop may be reused by this cycle's push
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        (n_push != '0) |-> (count - n_pop + n_push <= CNT_W'(DEPTH)))
        else $error("ex_buffer: push overflows the queue");

endmodule

// ==== hdl/dir_table.sv ====
// untagged counters indexed by the low IDX_W pc bits; only DIRECT updates train them
`timescale 1ns/100ps

module dir_table #(
    parameter int IDX_W = 4
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [bp_pkg::PC_W-1:0] fetch_pc,
    bp_upd_if.dst                   upd,
    output logic [1:0]              ctr
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << IDX_W;

    logic [1:0]       ctrs [ENTRIES];
    logic [IDX_W-1:0] wr_idx;
    logic [1:0]       cur;

    assign wr_idx = upd.pc[IDX_W-1:0];
    assign cur    = ctrs[wr_idx];

    // read sees the old value while a write is in flight
    assign ctr = ctrs[fetch_pc[IDX_W-1:0]];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++)
                ctrs[i] <= CTR_RESET;
        end else if (upd.valid && upd.kind == KIND_DIRECT) begin
            // saturate at 0 and 3
            if (upd.taken && cur != 2'b11)
                ctrs[wr_idx] <= cur + 2'b01;
            else if (!upd.taken && cur != 2'b00)
                ctrs[wr_idx] <= cur - 2'b01;
        end
    end

endmodule

// ==== hdl/target_table.sv ====
// direct mapped with IDX_W + TAG_W no wider than the pc; only taken updates allocate
`timescale 1ns/100ps

module target_table #(
    parameter int IDX_W = 4,
    parameter int TAG_W = 6
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [bp_pkg::PC_W-1:0]   fetch_pc,
    bp_upd_if.dst                     upd,
    output logic                      hit,
    output logic [bp_pkg::PC_W-1:0]   target,
    output logic [bp_pkg::KIND_W-1:0] kind
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << IDX_W;

    logic              ent_valid  [ENTRIES];
    logic [TAG_W-1:0]  ent_tag    [ENTRIES];
    logic [PC_W-1:0]   ent_target [ENTRIES];
    logic [KIND_W-1:0] ent_kind   [ENTRIES];

    logic [IDX_W-1:0]  rd_idx;
    logic [TAG_W-1:0]  rd_tag;
    logic [IDX_W-1:0]  wr_idx;
    logic [TAG_W-1:0]  wr_tag;
    logic              wr_en;

    assign rd_idx = fetch_pc[IDX_W-1:0];
    assign rd_tag = fetch_pc[IDX_W +: TAG_W];
    assign wr_idx = upd.pc[IDX_W-1:0];
    assign wr_tag = upd.pc[IDX_W +: TAG_W];

    // a not-taken update leaves the entry as it was
    assign wr_en = upd.valid && upd.taken;

    assign hit    = ent_valid[rd_idx] && (ent_tag[rd_idx] == rd_tag);
    assign target = ent_target[rd_idx];
    assign kind   = ent_kind[rd_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++)
                ent_valid[i] <= 1'b0;
        end else if (wr_en) begin
            ent_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_tag[wr_idx]    <= wr_tag;
            ent_target[wr_idx] <= upd.npc;
            ent_kind[wr_idx]   <= upd.kind;
        end
    end

    // a taken packet from the buffer always carries some branch kind
    a_taken_has_kind: assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> (upd.kind != KIND_NOT))
        else $error("target_table: taken update with kind NOT");

endmodule

// ==== hdl/pred_merge.sv ====
// prediction is registered, so it belongs to the fetch_pc of the previous cycle
`timescale 1ns/100ps

module pred_merge (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [bp_pkg::PC_W-1:0]   fetch_pc,
    input  logic [1:0]                ctr,
    input  logic                      hit,
    input  logic [bp_pkg::PC_W-1:0]   target,
    input  logic [bp_pkg::KIND_W-1:0] kind,
    output logic                      pred_taken,
    output logic [bp_pkg::KIND_W-1:0] pred_kind,
    output logic [bp_pkg::PC_W-1:0]   pred_npc
);
    import bp_pkg::*;

    logic uncond;
    logic take;

    assign uncond = (kind == KIND_CALL) || (kind == KIND_RET) ||
                    (kind == KIND_INDIRECT) || (kind == KIND_OTHER);

    // conditional branches follow the counter msb
    assign take = hit && (uncond || (kind == KIND_DIRECT && ctr[1]));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            pred_taken <= 1'b0;
        else
            pred_taken <= take;
    end

    always_ff @(posedge clk) begin
        pred_kind <= hit ? kind : KIND_NOT;
        pred_npc  <= take ? target : fetch_pc + PC_W'(1);
    end

endmodule

// ==== hdl/bp_top.sv ====
// no back-pressure toward execute; DEPTH must cover the worst run of incomplete packets
`timescale 1ns/100ps

module bp_top #(
    parameter int DEPTH = 8,
    parameter int IDX_W = 4,
    parameter int TAG_W = 6
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      stall,
    input  logic                      ex0_valid,
    input  logic [bp_pkg::PC_W-1:0]   ex0_pc,
    input  logic                      ex0_taken,
    input  logic [bp_pkg::KIND_W-1:0] ex0_kind,
    input  logic [bp_pkg::PC_W-1:0]   ex0_npc,
    input  logic                      ex1_valid,
    input  logic [bp_pkg::PC_W-1:0]   ex1_pc,
    input  logic                      ex1_taken,
    input  logic [bp_pkg::KIND_W-1:0] ex1_kind,
    input  logic [bp_pkg::PC_W-1:0]   ex1_npc,
    input  logic [bp_pkg::PC_W-1:0]   fetch_pc,
    output logic                      upd_valid,
    output logic [bp_pkg::PC_W-1:0]   upd_pc,
    output logic                      upd_taken,
    output logic [bp_pkg::KIND_W-1:0] upd_kind,
    output logic [bp_pkg::PC_W-1:0]   upd_npc,
    output logic                      pred_taken,
    output logic [bp_pkg::KIND_W-1:0] pred_kind,
    output logic [bp_pkg::PC_W-1:0]   pred_npc
);

    bp_upd_if upd_bus ();

    logic [1:0]                ctr;
    logic                      tt_hit;
    logic [bp_pkg::PC_W-1:0]   tt_target;
    logic [bp_pkg::KIND_W-1:0] tt_kind;

    assign upd_valid = upd_bus.valid;
    assign upd_pc    = upd_bus.pc;
    assign upd_taken = upd_bus.taken;
    assign upd_kind  = upd_bus.kind;
    assign upd_npc   = upd_bus.npc;

    ex_buffer #(.DEPTH(DEPTH)) ex_buffer_i (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .ex0_valid (ex0_valid),
        .ex0_pc    (ex0_pc),
        .ex0_taken (ex0_taken),
        .ex0_kind  (ex0_kind),
        .ex0_npc   (ex0_npc),
        .ex1_valid (ex1_valid),
        .ex1_pc    (ex1_pc),
        .ex1_taken (ex1_taken),
        .ex1_kind  (ex1_kind),
        .ex1_npc   (ex1_npc),
        .upd       (upd_bus.src)
    );

    dir_table #(.IDX_W(IDX_W)) dir_table_i (
        .clk      (clk),
        .rstn     (rstn),
        .fetch_pc (fetch_pc),
        .upd      (upd_bus.dst),
        .ctr      (ctr)
    );

    target_table #(.IDX_W(IDX_W), .TAG_W(TAG_W)) target_table_i (
        .clk      (clk),
        .rstn     (rstn),
        .fetch_pc (fetch_pc),
        .upd      (upd_bus.dst),
        .hit      (tt_hit),
        .target   (tt_target),
        .kind     (tt_kind)
    );

    pred_merge pred_merge_i (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_pc   (fetch_pc),
        .ctr        (ctr),
        .hit        (tt_hit),
        .target     (tt_target),
        .kind       (tt_kind),
        .pred_taken (pred_taken),
        .pred_kind  (pred_kind),
        .pred_npc   (pred_npc)
    );

endmodule

// ==== bench/bp_top_tb.sv ====
// checks updates in order and predictions one cycle after fetch_pc; assumes DEPTH=8, IDX_W=4, TAG_W=6
`timescale 1ns/100ps

module bp_top_tb;
    import bp_pkg::*;

    localparam int DEPTH = 8;
    localparam int IDX_W = 4;
    localparam int TAG_W = 6;

    typedef struct packed {
        logic              stall;
        logic              v0;
        logic [PC_W-1:0]   pc0;
        logic              t0;
        logic [KIND_W-1:0] k0;
        logic [PC_W-1:0]   n0;
        logic              v1;
        logic [PC_W-1:0]   pc1;
        logic              t1;
        logic [KIND_W-1:0] k1;
        logic [PC_W-1:0]   n1;
        logic [PC_W-1:0]   fpc;
    } row_t;

    // fields of one resolved record or of one merged update
    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic              taken;
        logic [KIND_W-1:0] kind;
        logic [PC_W-1:0]   npc;
    } rec_t;

    logic clk = 1'b0;
    logic rstn;
    logic stall;
    logic ex0_valid, ex1_valid;
    logic [PC_W-1:0] ex0_pc, ex0_npc, ex1_pc, ex1_npc, fetch_pc;
    logic ex0_taken, ex1_taken;
    logic [KIND_W-1:0] ex0_kind, ex1_kind;
    logic upd_valid, upd_taken, pred_taken;
    logic [PC_W-1:0] upd_pc, upd_npc, pred_npc;
    logic [KIND_W-1:0] upd_kind, pred_kind;

    row_t rows[$];
    rec_t rec_q[$];
    rec_t exp_q[$];

    logic [1:0]        sh_ctr   [1 << IDX_W];
    logic              sh_valid [1 << IDX_W];
    logic [TAG_W-1:0]  sh_tag   [1 << IDX_W];
    logic [PC_W-1:0]   sh_tgt   [1 << IDX_W];
    logic [KIND_W-1:0] sh_kind  [1 << IDX_W];

    rec_t            pend;
    logic            pend_v;
    logic [PC_W-1:0] prev_fetch;
    logic            mon_on = 1'b0;
    int              cycles = 0;
    int              limit = 100000;

    bp_top #(.DEPTH(DEPTH), .IDX_W(IDX_W), .TAG_W(TAG_W)) bp_top_i (.*);

    always #5 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_upd(input logic [PC_W-1:0] pc, input logic taken,
                             input logic [KIND_W-1:0] kind, input logic [PC_W-1:0] npc,
                             input rec_t e);
        if (pc !== e.pc)
            report_fail($sformatf("FAILED upd_pc got %h exp %h", pc, e.pc));
        if (taken !== e.taken)
            report_fail($sformatf("FAILED upd_taken got %h exp %h", taken, e.taken));
        if (kind !== e.kind)
            report_fail($sformatf("FAILED upd_kind got %h exp %h", kind, e.kind));
        if (npc !== e.npc)
            report_fail($sformatf("FAILED upd_npc got %h exp %h", npc, e.npc));
    endtask

    task automatic check_pred(input logic taken, input logic [KIND_W-1:0] kind,
                              input logic [PC_W-1:0] npc, input logic e_taken,
                              input logic [KIND_W-1:0] e_kind, input logic [PC_W-1:0] e_npc);
        if (taken !== e_taken)
            report_fail($sformatf("FAILED pred_taken got %h exp %h", taken, e_taken));
        if (kind !== e_kind)
            report_fail($sformatf("FAILED pred_kind got %h exp %h", kind, e_kind));
        if (npc !== e_npc)
            report_fail($sformatf("FAILED pred_npc got %h exp %h", npc, e_npc));
    endtask

    // higher rank wins when two records merge
    function automatic int kind_rank(input logic [KIND_W-1:0] k);
        case (k)
            KIND_DIRECT:   return 5;
            KIND_CALL:     return 4;
            KIND_RET:      return 3;
            KIND_INDIRECT: return 2;
            KIND_OTHER:    return 1;
            default:       return 0;
        endcase
    endfunction

    task automatic add_row(input logic st, input logic v0, input int pc0, input logic t0,
                           input logic [KIND_W-1:0] k0, input int n0, input logic v1,
                           input int pc1, input logic t1, input logic [KIND_W-1:0] k1,
                           input int n1, input int fpc);
        row_t r;
        r = '{st, v0, PC_W'(pc0), t0, k0, PC_W'(n0), v1, PC_W'(pc1), t1, k1, PC_W'(n1),
              PC_W'(fpc)};
        rows.push_back(r);
    endtask

    // queue model pushes the records and then forms every complete packet
    task automatic model_push(input row_t r);
        rec_t a;
        rec_t b;
        rec_t m;
        if (r.stall)
            return;
        if (r.v0)
            rec_q.push_back('{r.pc0, r.t0, r.k0, r.n0});
        if (r.v1)
            rec_q.push_back('{r.pc1, r.t1, r.k1, r.n1});
        forever begin
            if (rec_q.size() == 0)
                break;
            a = rec_q[0];
            if (a.pc[0]) begin
                exp_q.push_back(rec_q.pop_front());
                continue;
            end
            if (rec_q.size() < 2)
                break;
            a = rec_q.pop_front();
            b = rec_q.pop_front();
            m.pc    = a.pc;
            m.taken = a.taken | b.taken;
            m.kind  = (kind_rank(a.kind) >= kind_rank(b.kind)) ? a.kind : b.kind;
            m.npc   = a.taken ? a.npc : b.npc;
            exp_q.push_back(m);
        end
    endtask

    task automatic apply_row(input row_t r);
        stall     = r.stall;
        ex0_valid = r.v0;
        ex0_pc    = r.pc0;
        ex0_taken = r.t0;
        ex0_kind  = r.k0;
        ex0_npc   = r.n0;
        ex1_valid = r.v1;
        ex1_pc    = r.pc1;
        ex1_taken = r.t1;
        ex1_kind  = r.k1;
        ex1_npc   = r.n1;
        fetch_pc  = r.fpc;
    endtask

    // shadow tables take an update one cycle after it shows on upd_valid
    task automatic shadow_write(input rec_t u);
        int i;
        i = int'(u.pc[IDX_W-1:0]);
        if (u.kind == KIND_DIRECT) begin
            if (u.taken && sh_ctr[i] < 2'd3)
                sh_ctr[i] = sh_ctr[i] + 2'd1;
            else if (!u.taken && sh_ctr[i] > 2'd0)
                sh_ctr[i] = sh_ctr[i] - 2'd1;
        end
        if (u.taken) begin
            sh_valid[i] = 1'b1;
            sh_tag[i]   = u.pc[IDX_W +: TAG_W];
            sh_tgt[i]   = u.npc;
            sh_kind[i]  = u.kind;
        end
    endtask

    always @(negedge clk) begin
        int   i;
        logic hit;
        logic tk;
        if (mon_on) begin
            i   = int'(prev_fetch[IDX_W-1:0]);
            hit = sh_valid[i] && sh_tag[i] == prev_fetch[IDX_W +: TAG_W];
            tk  = hit && (sh_kind[i] inside {KIND_CALL, KIND_RET, KIND_INDIRECT, KIND_OTHER} ||
                          (sh_kind[i] == KIND_DIRECT && sh_ctr[i][1]));
            check_pred(pred_taken, pred_kind, pred_npc, tk, hit ? sh_kind[i] : KIND_NOT,
                       tk ? sh_tgt[i] : prev_fetch + PC_W'(1));
            if (pend_v)
                shadow_write(pend);
            pend_v = 1'b0;
            if (upd_valid) begin
                if (exp_q.size() == 0)
                    report_fail("update seen while no packet was expected");
                pend = exp_q.pop_front();
                check_upd(upd_pc, upd_taken, upd_kind, upd_npc, pend);
                pend_v = 1'b1;
            end
            prev_fetch = fetch_pc;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            report_fail("timeout, DUT did not deliver all expected updates");
    end

    initial begin
        void'($urandom(32'h89ae80a4));
        rstn   = 1'b0;
        pend_v = 1'b0;
        for (int i = 0; i < (1 << IDX_W); i++) begin
            sh_ctr[i]   = CTR_RESET;
            sh_valid[i] = 1'b0;
        end
        apply_row('{default: '0, fpc: PC_W'('h10)});

        add_row(0, 1, 'h011, 1, KIND_CALL, 'h200, 0, 0, 0, KIND_NOT, 0, 'h011);
        add_row(0, 1, 'h023, 0, KIND_DIRECT, $urandom, 1, 'h035, 1, KIND_RET, 'h300, 'h011);
        add_row(0, 1, 'h040, 1, KIND_OTHER, 'h400, 1, 'h041, 0, KIND_DIRECT, 'h042, 'h021);
        add_row(0, 1, 'h050, 0, KIND_NOT, $urandom, 0, 0, 0, KIND_NOT, 0, 'h011);
        add_row(0, 1, 'h051, 1, KIND_CALL, 'h500, 1, 'h061, 1, KIND_DIRECT, 'h600, 'h040);
        add_row(0, 1, 'h070, 1, KIND_RET, 'h700, 1, 'h071, 0, KIND_NOT, $urandom, 'h051);
        add_row(0, 1, 'h080, 0, KIND_DIRECT, $urandom, 0, 0, 0, KIND_NOT, 0, 'h061);
        add_row(0, 1, 'h081, 1, KIND_INDIRECT, 'h800, 1, 'h090, 0, KIND_NOT, $urandom, 'h070);
        add_row(0, 1, 'h091, 0, KIND_DIRECT, $urandom, 0, 0, 0, KIND_NOT, 0, 'h080);
        add_row(1, 1, 'h0a3, 1, KIND_DIRECT, 'ha00, 1, 'h0b1, 1, KIND_OTHER, 'hb00, 'h0a3);
        add_row(1, 1, 'h0a3, 1, KIND_DIRECT, 'ha00, 1, 'h0b1, 1, KIND_OTHER, 'hb00, 'h0a3);
        add_row(0, 1, 'h0a3, 1, KIND_DIRECT, 'ha00, 1, 'h0b1, 1, KIND_OTHER, 'hb00, 'h0a3);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h0a3);
        add_row(0, 1, 'h0a3, 1, KIND_DIRECT, 'ha00, 0, 0, 0, KIND_NOT, 0, 'h0a3);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h0a3);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h0a3);
        add_row(0, 1, 'h0a3, 0, KIND_DIRECT, $urandom, 0, 0, 0, KIND_NOT, 0, 'h0b1);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h0a3);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h0a3);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h081);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h0b1);
        add_row(0, 0, 0, 0, KIND_NOT, 0, 0, 0, 0, KIND_NOT, 0, 'h3c1);
        limit = 16 + 4 * rows.size() + 50;

        repeat (15) @(posedge clk);
        @(negedge clk);
        if (upd_valid !== 1'b0)
            report_fail($sformatf("FAILED upd_valid got %h exp %h", upd_valid, 1'b0));
        check_pred(pred_taken, pred_kind, pred_npc, 1'b0, KIND_NOT, fetch_pc + PC_W'(1));
        @(posedge clk);
        #1;
        rstn       = 1'b1;
        prev_fetch = fetch_pc;
        mon_on     = 1'b1;

        foreach (rows[n]) begin
            @(posedge clk);
            #1;
            apply_row(rows[n]);
            model_push(rows[n]);
        end
        @(posedge clk);
        #1;
        apply_row('{default: '0, fpc: PC_W'('h011)});
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/bp_pkg.sv
hdl/bp_upd_if.sv
hdl/ex_buffer.sv
hdl/dir_table.sv
hdl/target_table.sv
hdl/pred_merge.sv
hdl/bp_top.sv
bench/bp_top_tb.sv

// ==== Makefile ====
# Verilator flow for the branch predictor update path

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= bp_top_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) hdl/*.sv bench/*.sv
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)
